// ==== source/l1_ld_pkg.sv ====
package l1_ld_pkg;

	// --------------------------------------------------
	// Widths
	// --------------------------------------------------
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;
	// Wide enough for any depth, tags are zero-extended
	localparam int TAG_W  = 16;

	// Word address of a load or a fill
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [TAG_W-1:0]  tag_t;

	// One tag memory line, cleared entry reads as invalid
	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	// --------------------------------------------------
	// Address helpers
	// --------------------------------------------------
	// Upper address bits above the index, zero-extended
	function automatic tag_t addr_tag(addr_t addr, int unsigned idx_w);
		return tag_t'(addr >> idx_w);
	endfunction

	// Valid entry for a fill to this address
	function automatic tag_entry_t make_tag_entry(addr_t addr, int unsigned idx_w);
		tag_entry_t entry;
		entry.valid = 1'b1;
		entry.tag   = addr_tag(addr, idx_w);
		return entry;
	endfunction

endpackage

// ==== source/sram_dp.sv ====
`timescale 1ns/1ns

module sram_dp #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 64
) (
	input  logic                     CLK,
	// Write port
	input  logic                     wen,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  logic [WIDTH-1:0]         wdata,
	// Read port
	input  logic                     ren,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output logic [WIDTH-1:0]         rdata
);

	// Storage array
	logic [WIDTH-1:0] mem [DEPTH];

	// Write side
	always_ff @(posedge CLK) begin
		if (wen) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read, one cycle latency
	// Output holds while ren is low
	always_ff @(posedge CLK) begin
		if (ren) begin
			rdata <= mem[raddr];
		end
	end

endmodule

// ==== source/l1_ld_dp_mem.sv ====
`timescale 1ns/1ns

module l1_ld_dp_mem #(
	parameter int DEPTH = 64,
	parameter type T = logic [31:0]
) (
	input  logic                     CLK,
	input  logic                     RST_N,
	// Read side
	input  logic                     ren,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output T                         rdata,
	// External write side
	input  logic                     wen,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  T                         wdata,
	// Clear done
	output logic                     ready
);

	localparam int IDX_W = $clog2(DEPTH);

	logic             clearing;
	logic [IDX_W-1:0] clr_addr;

	logic             mem_wen;
	logic [IDX_W-1:0] mem_waddr;
	T                 mem_wdata;

	// --------------------------------------------------
	// Clear walk after reset
	// --------------------------------------------------
	// One address per cycle, done after the last one
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			clearing <= 1'b1;
			clr_addr <= '0;
		end else if (clearing) begin
			clr_addr <= clr_addr + 1'b1;
			if (clr_addr == IDX_W'(DEPTH - 1)) begin
				clearing <= 1'b0;
			end
		end
	end

	assign ready = ~clearing;

	// Write port owned by the clear walk until it ends
	assign mem_wen   = clearing ? 1'b1     : wen;
	assign mem_waddr = clearing ? clr_addr : waddr;
	assign mem_wdata = clearing ? T'('0)   : wdata;

	sram_dp #(
		.WIDTH ($bits(T)),
		.DEPTH (DEPTH)
	) u_sram (
		.CLK   (CLK),
		.wen   (mem_wen),
		.waddr (mem_waddr),
		.wdata (mem_wdata),
		.ren   (ren),
		.raddr (raddr),
		.rdata (rdata)
	);

	// Reader must hold off until the clear is over
	a_no_read_before_ready: assert property (
		@(posedge CLK) disable iff (!RST_N) !ready |-> !ren
	);

endmodule

// ==== source/l1_ld_pipe_if.sv ====
`timescale 1ns/1ns

// Execute to result bundle
interface l1_ld_pipe_if
	import l1_ld_pkg::*;
();

	logic  valid;
	// Stored line valid and tag matched
	logic  hit;
	// Request address, echoed in the response
	addr_t addr;
	// Line data, may be stale on a miss
	data_t data;

	// Execute side
	modport drv (
		output valid,
		output hit,
		output addr,
		output data
	);

	// Result side
	modport rcv (
		input valid,
		input hit,
		input addr,
		input data
	);

endinterface

// ==== source/l1_ld_decode.sv ====
`timescale 1ns/1ns

module l1_ld_decode
	import l1_ld_pkg::*;
#(
	parameter int DEPTH = 64
) (
	input  logic                     CLK,
	input  logic                     RST_N,
	input  logic                     ready,
	// Load request strobe
	input  logic                     req_valid,
	input  addr_t                    req_addr,
	// Read issue to both memories
	output logic                     mem_ren,
	output logic [$clog2(DEPTH)-1:0] mem_raddr,
	// To execute
	output logic                     dec_valid,
	output tag_t                     dec_tag,
	output addr_t                    dec_addr
);

	localparam int IDX_W = $clog2(DEPTH);

	// --------------------------------------------------
	// Read issue
	// --------------------------------------------------
	// Requests during the clear are dropped here
	assign mem_ren   = req_valid & ready;
	assign mem_raddr = req_addr[IDX_W-1:0];

	// Valid lines up with memory read data
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= mem_ren;
		end
	end

	// Tag and address only move on an accepted request
	always_ff @(posedge CLK) begin
		if (mem_ren) begin
			dec_tag  <= addr_tag(req_addr, IDX_W);
			dec_addr <= req_addr;
		end
	end

endmodule

// ==== source/l1_ld_execute.sv ====
`timescale 1ns/1ns

module l1_ld_execute
	import l1_ld_pkg::*;
(
	input  logic            CLK,
	input  logic            RST_N,
	// From decode
	input  logic            dec_valid,
	input  tag_t            dec_tag,
	input  addr_t           dec_addr,
	// Memory read data, same cycle as decode outputs
	input  tag_entry_t      tag_rdata,
	input  data_t           data_rdata,
	// To result
	l1_ld_pipe_if.drv       pipe
);

	logic hit;

	// --------------------------------------------------
	// Tag compare
	// --------------------------------------------------
	// Cleared lines never match, valid bit is zero
	assign hit = dec_valid & tag_rdata.valid & (tag_rdata.tag == dec_tag);

	// Control bits
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pipe.valid <= 1'b0;
			pipe.hit   <= 1'b0;
		end else begin
			pipe.valid <= dec_valid;
			pipe.hit   <= hit;
		end
	end

	// Payload
	// Data taken as read, result decides whether it leaves
	always_ff @(posedge CLK) begin
		if (dec_valid) begin
			pipe.addr <= dec_addr;
			pipe.data <= data_rdata;
		end
	end

	// A hit only ever comes from an accepted decode
	a_hit_has_valid: assert property (
		@(posedge CLK) disable iff (!RST_N)
		pipe.hit |-> pipe.valid && $past(dec_valid)
	);

endmodule

// ==== source/l1_ld_result.sv ====
`timescale 1ns/1ns

module l1_ld_result
	import l1_ld_pkg::*;
(
	input  logic      CLK,
	input  logic      RST_N,
	// From execute
	l1_ld_pipe_if.rcv pipe,
	// Load response
	output logic      resp_valid,
	output logic      resp_hit,
	output addr_t     resp_addr,
	output data_t     resp_data
);

	// --------------------------------------------------
	// Response register
	// --------------------------------------------------
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			resp_valid <= 1'b0;
			resp_hit   <= 1'b0;
		end else begin
			resp_valid <= pipe.valid;
			resp_hit   <= pipe.hit;
		end
	end

	// Miss returns zero, stale line never leaves
	always_ff @(posedge CLK) begin
		if (pipe.valid) begin
			resp_addr <= pipe.addr;
			resp_data <= pipe.hit ? pipe.data : '0;
		end
	end

	// Miss response carries zero data
	a_miss_zero_data: assert property (
		@(posedge CLK) disable iff (!RST_N)
		resp_valid && !resp_hit |-> resp_data == '0
	);

endmodule

// ==== source/l1_ld_top.sv ====
`timescale 1ns/1ns

module l1_ld_top
	import l1_ld_pkg::*;
#(
	parameter int DEPTH = 64
) (
	input  logic  CLK,
	input  logic  RST_N,
	// Load request
	input  logic  req_valid,
	input  addr_t req_addr,
	// Line fill
	input  logic  fill_valid,
	input  addr_t fill_addr,
	input  data_t fill_data,
	// Status and response
	output logic  ready,
	output logic  resp_valid,
	output logic  resp_hit,
	output addr_t resp_addr,
	output data_t resp_data
);

	localparam int IDX_W = $clog2(DEPTH);

	logic             mem_ren;
	logic [IDX_W-1:0] mem_raddr;
	logic             dec_valid;
	tag_t             dec_tag;
	addr_t            dec_addr;
	tag_entry_t       tag_rdata;
	data_t            data_rdata;
	tag_entry_t       fill_entry;

	l1_ld_pipe_if pipe ();

	// --------------------------------------------------
	// Fill path, same index in both memories
	// --------------------------------------------------
	assign fill_entry = make_tag_entry(fill_addr, IDX_W);

	// Tag memory ready stands for both, they clear in lockstep
	l1_ld_dp_mem #(.DEPTH(DEPTH), .T(tag_entry_t)) tag_mem (
		.CLK(CLK), .RST_N(RST_N), .ren(mem_ren), .raddr(mem_raddr), .rdata(tag_rdata),
		.wen(fill_valid), .waddr(fill_addr[IDX_W-1:0]), .wdata(fill_entry), .ready(ready)
	);

	l1_ld_dp_mem #(.DEPTH(DEPTH), .T(data_t)) data_mem (
		.CLK(CLK), .RST_N(RST_N), .ren(mem_ren), .raddr(mem_raddr), .rdata(data_rdata),
		.wen(fill_valid), .waddr(fill_addr[IDX_W-1:0]), .wdata(fill_data), .ready()
	);

	// --------------------------------------------------
	// Load pipeline
	// --------------------------------------------------
	l1_ld_decode #(.DEPTH(DEPTH)) u_decode (
		.CLK(CLK), .RST_N(RST_N), .ready(ready), .req_valid(req_valid), .req_addr(req_addr),
		.mem_ren(mem_ren), .mem_raddr(mem_raddr),
		.dec_valid(dec_valid), .dec_tag(dec_tag), .dec_addr(dec_addr)
	);

	l1_ld_execute u_execute (
		.CLK(CLK), .RST_N(RST_N), .dec_valid(dec_valid), .dec_tag(dec_tag),
		.dec_addr(dec_addr), .tag_rdata(tag_rdata), .data_rdata(data_rdata), .pipe(pipe)
	);

	l1_ld_result u_result (
		.CLK(CLK), .RST_N(RST_N), .pipe(pipe), .resp_valid(resp_valid),
		.resp_hit(resp_hit), .resp_addr(resp_addr), .resp_data(resp_data)
	);

endmodule

// ==== verification/l1_ld_tb.sv ====
`timescale 1ns/1ns

module l1_ld_tb
	import l1_ld_pkg::*;
();

	localparam int DEPTH   = 64;
	localparam int TIMEOUT = 200;

	logic  CLK;
	logic  RST_N;
	logic  req_valid;
	addr_t req_addr;
	logic  fill_valid;
	addr_t fill_addr;
	data_t fill_data;
	logic  ready;
	logic  resp_valid;
	logic  resp_hit;
	addr_t resp_addr;
	data_t resp_data;

	// Reference model, one line per index
	logic  ref_valid [DEPTH];
	addr_t ref_tag   [DEPTH];
	data_t ref_data  [DEPTH];

	// Expected responses in request order, with the cycle they are due
	int    exp_due  [$];
	logic  exp_hit  [$];
	addr_t exp_addr [$];
	data_t exp_data [$];

	int cycle;
	int fail_count;

	l1_ld_top #(.DEPTH(DEPTH)) uut (
		.CLK(CLK), .RST_N(RST_N), .req_valid(req_valid), .req_addr(req_addr),
		.fill_valid(fill_valid), .fill_addr(fill_addr), .fill_data(fill_data),
		.ready(ready), .resp_valid(resp_valid), .resp_hit(resp_hit),
		.resp_addr(resp_addr), .resp_data(resp_data)
	);

	// 4 ns clock
	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// --------------------------------------------------
	// Reporting
	// --------------------------------------------------
	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		fail_count++;
		$display("error %s got 0x%h expected 0x%h", name, got, exp);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		fail_count++;
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1);
	endtask

	// --------------------------------------------------
	// Per cycle response check
	// --------------------------------------------------
	// Either the oldest queued response is due now, or nothing comes out
	task automatic check_response();
		if (exp_due.size() != 0 && exp_due[0] == cycle) begin
			assert (resp_valid === 1'b1) else report_mismatch("resp_valid", resp_valid, 1);
			assert (resp_hit === exp_hit[0]) else report_mismatch("resp_hit", resp_hit, exp_hit[0]);
			assert (resp_addr === exp_addr[0])
				else report_mismatch("resp_addr", resp_addr, exp_addr[0]);
			assert (resp_data === exp_data[0])
				else report_mismatch("resp_data", resp_data, exp_data[0]);
			exp_due.delete(0);
			exp_hit.delete(0);
			exp_addr.delete(0);
			exp_data.delete(0);
		end else begin
			assert (resp_valid === 1'b0) else report_mismatch("resp_valid", resp_valid, 0);
		end
	endtask

	// Outputs settle right after the edge, inputs change at the same point
	task automatic step();
		@(posedge CLK);
		#1;
		cycle++;
		check_response();
	endtask

	// Low address bits pick the line, the rest is the tag
	task automatic predict(input addr_t addr, output logic hit, output data_t data);
		int idx;
		idx  = addr % DEPTH;
		hit  = ref_valid[idx] && (ref_tag[idx] == addr / DEPTH);
		data = hit ? ref_data[idx] : '0;
	endtask

	// Sampled at the next edge, response two edges after that
	task automatic drive_load(input addr_t addr, input logic hit, input data_t data);
		fill_valid = 1'b0;
		req_valid  = 1'b1;
		req_addr   = addr;
		exp_due.push_back(cycle + 3);
		exp_hit.push_back(hit);
		exp_addr.push_back(addr);
		exp_data.push_back(hit ? data : '0);
	endtask

	task automatic drive_fill(input addr_t addr, input data_t data);
		req_valid  = 1'b0;
		fill_valid = 1'b1;
		fill_addr  = addr;
		fill_data  = data;
		ref_valid[addr % DEPTH] = 1'b1;
		ref_tag[addr % DEPTH]   = addr / DEPTH;
		ref_data[addr % DEPTH]  = data;
	endtask

	// Idle until every queued response came out
	task automatic drain();
		int i;
		req_valid  = 1'b0;
		fill_valid = 1'b0;
		for (i = 0; i < 8 && exp_due.size() != 0; i++) begin
			step();
		end
		assert (exp_due.size() == 0) else report_failure("Responses missing after drain timeout");
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		int              n;
		int              fd;
		int              i;
		bit              more;
		logic [63:0]     op_word;
		logic [8*80-1:0] line_buf;
		addr_t           c_addr;
		data_t           c_data;
		logic            c_hit;
		data_t           c_exp;
		logic            m_hit;
		data_t           m_data;
		addr_t           r_addr;

		RST_N      = 1'b0;
		req_valid  = 1'b0;
		req_addr   = '0;
		fill_valid = 1'b0;
		fill_addr  = '0;
		fill_data  = '0;
		cycle      = 0;
		fail_count = 0;
		void'($urandom(32'h7618));
		// Model starts out cleared like the cache
		for (i = 0; i < DEPTH; i++) begin
			ref_valid[i] = 1'b0;
		end

		// Reset for two cycles
		repeat (2) step();
		assert (ready === 1'b0) else report_mismatch("ready", ready, 0);
		assert (resp_hit === 1'b0) else report_mismatch("resp_hit", resp_hit, 0);
		RST_N = 1'b1;

		// Clear walk, requests meanwhile are dropped
		n = 0;
		req_valid = 1'b1;
		while (ready !== 1'b1 && n < TIMEOUT) begin
			req_addr = addr_t'($urandom);
			step();
			n++;
		end
		req_valid = 1'b0;
		assert (ready === 1'b1) else report_failure("ready did not rise after the clear");
		assert (n == DEPTH) else report_mismatch("ready delay", n, DEPTH);
		repeat (4) step();

		// Cleared cache, back to back random loads all miss
		for (i = 0; i < 32; i++) begin
			r_addr = addr_t'($urandom);
			predict(r_addr, m_hit, m_data);
			drive_load(r_addr, m_hit, m_data);
			step();
		end
		drain();

		// Directed fills and loads, one per cycle
		fd = $fopen("verification/l1_ld_cases.txt", "r");
		assert (fd != 0) else report_failure("Cannot open verification/l1_ld_cases.txt");
		more = 1'b1;
		while (more) begin
			n = $fscanf(fd, "%s", op_word);
			if (n != 1) begin
				more = 1'b0;
			end else if (op_word == "#") begin
				n = $fgets(line_buf, fd);
			end else begin
				n = $fscanf(fd, "%h %h %h %h", c_addr, c_data, c_hit, c_exp);
				assert (n == 4) else report_failure("Malformed line in case file");
				assert (op_word == "F" || op_word == "L")
					else report_failure("Unknown operation in case file");
				if (op_word == "F") begin
					drive_fill(c_addr, c_data);
				end else begin
					// File and model must agree
					predict(c_addr, m_hit, m_data);
					assert (c_hit === m_hit) else report_mismatch("case exp_hit", c_hit, m_hit);
					assert (c_exp === m_data) else report_mismatch("case exp_data", c_exp, m_data);
					drive_load(c_addr, c_hit, c_exp);
				end
				step();
			end
		end
		$fclose(fd);
		drain();

		if (fail_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== verification/l1_ld_cases.txt ====
# op addr data exp_hit exp_data, all fields in hex
# F fills a line (last two ignored), L loads and expects hit and data
F 0041 cafe0001 0 00000000
L 0041 00000000 1 cafe0001
F 1205 12345678 0 00000000
L 1205 00000000 1 12345678
L 0001 00000000 0 00000000
L 00c1 00000000 0 00000000
F 00c1 beef00c1 0 00000000
L 00c1 00000000 1 beef00c1
L 0041 00000000 0 00000000
L 1205 00000000 1 12345678
F ffff 0f0f0f0f 0 00000000
L ffff 00000000 1 0f0f0f0f
L 003f 00000000 0 00000000
L 0000 00000000 0 00000000

// ==== sources.f ====
source/l1_ld_pkg.sv
source/sram_dp.sv
source/l1_ld_dp_mem.sv
source/l1_ld_pipe_if.sv
source/l1_ld_decode.sv
source/l1_ld_execute.sv
source/l1_ld_result.sv
source/l1_ld_top.sv
verification/l1_ld_tb.sv

// ==== Bender.yml ====
package:
  name: l1_ld

sources:
  - source/l1_ld_pkg.sv
  - source/sram_dp.sv
  - source/l1_ld_dp_mem.sv
  - source/l1_ld_pipe_if.sv
  - source/l1_ld_decode.sv
  - source/l1_ld_execute.sv
  - source/l1_ld_result.sv
  - source/l1_ld_top.sv
  - target: test
    files:
      - verification/l1_ld_tb.sv
